/* quad_cmd_pkg.sv */
package quad_cmd_pkg;

    typedef logic [7:0]  opcode_t;          // command opcode
    typedef logic [15:0] data16_t;          // command operand
    typedef logic [7:0]  resp_t;            // response byte, also one serial byte
    typedef logic [8:0]  thrust_t;          // thrust setpoint

    // one command as sent on the wire: opcode, then data high, then data low
    typedef struct packed {
        opcode_t opcode;
        data16_t data;
    } cmd_pkt_t;                            // 24 bits

    typedef struct packed {
        data16_t d_ptch;                    // desired pitch
        data16_t d_roll;                    // desired roll
        data16_t d_yaw;                     // desired yaw
        thrust_t thrst;                     // thrust
    } setpt_t;                              // 57 bits

    localparam opcode_t OP_SET_PTCH  = 8'h02;
    localparam opcode_t OP_SET_ROLL  = 8'h03;
    localparam opcode_t OP_SET_YAW   = 8'h04;
    localparam opcode_t OP_SET_THRST = 8'h05;
    localparam opcode_t OP_CAL       = 8'h06;   // spin up, then inertial calibration
    localparam opcode_t OP_EMER      = 8'h07;   // emergency land, all setpoints to zero
    localparam opcode_t OP_MTRS_OFF  = 8'h08;

    localparam resp_t RESP_ACK = 8'hA5;
    localparam resp_t RESP_NAK = 8'hEE;     // unknown opcode

    // command configurator states
    typedef enum logic [1:0] {
        IDLE,                               // waiting for cmd_rdy
        SPINUP,                             // motors spinning up before cal
        CAL,                                // waiting on cal_done
        RESP                                // one cycle while cmd_rdy clears
    } cal_state_t;

endpackage

/* uart_tx.sv */
module uart_tx
    import quad_cmd_pkg::*;
#(
    parameter int BAUD_DIV = 434                // clocks per bit
)
(
    input  logic  clk,
    input  logic  rst_n,
    input  resp_t byte_in,                      // byte to send
    input  logic  send,                         // one-cycle start strobe
    output logic  tx,                           // serial out, idles high
    output logic  busy,                         // frame in flight
    output logic  done                          // last cycle of stop bit
);

    localparam int CW = $clog2(BAUD_DIV);
    localparam logic [CW-1:0] BAUD_LAST = CW'(BAUD_DIV - 1);

    logic [CW-1:0] baud_cnt;                    // clocks within current bit
    logic [3:0]    bit_cnt;                     // 0 start, 1..8 data, 9 stop
    logic [9:0]    shft;                        // stop, data, start; lsb on the line
    logic          baud_end;

    assign baud_end = (baud_cnt == BAUD_LAST);
    assign tx       = shft[0];
    assign done     = busy && baud_end && (bit_cnt == 4'd9);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shft     <= '1;                     // line high out of reset
        end
        else if (!busy)
        begin
            if (send)                           // strobes while busy are dropped
            begin
                busy     <= 1'b1;
                shft     <= {1'b1, byte_in, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end
        else if (baud_end)
        begin
            baud_cnt <= '0;
            shft     <= {1'b1, shft[9:1]};     // fill with idle level
            if (bit_cnt == 4'd9)
                busy <= 1'b0;                   // stop bit finished
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
        else
            baud_cnt <= baud_cnt + 1'b1;
    end

endmodule

/* uart_rx.sv */
module uart_rx
    import quad_cmd_pkg::*;
#(
    parameter int BAUD_DIV = 434                // clocks per bit
)
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,                           // async serial in
    output resp_t byte_out,                     // last byte received
    output logic  rdy                           // pulse, middle of stop bit
);

    localparam int CW = $clog2(BAUD_DIV);
    localparam logic [CW-1:0] BAUD_LAST = CW'(BAUD_DIV - 1);
    localparam logic [CW-1:0] BAUD_MID  = CW'(BAUD_DIV / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t     state;
    logic          rx_ff1;                      // first sync stage
    logic          rx_s;                        // synchronized line
    logic [CW-1:0] baud_cnt;
    logic [2:0]    bit_cnt;                     // data bit index
    logic          sample;                      // mid-bit of a data bit
    resp_t         shft;

    assign sample   = (state == DATA) && (baud_cnt == BAUD_LAST);
    assign byte_out = shft;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rx_ff1 <= 1'b1;
            rx_s   <= 1'b1;
        end
        else
        begin
            rx_ff1 <= rx;
            rx_s   <= rx_ff1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rdy      <= 1'b0;
        end
        else
        begin
            rdy <= 1'b0;
            case (state)
                IDLE:
                begin
                    baud_cnt <= '0;
                    if (!rx_s)
                        state <= START;         // falling edge, maybe a start bit
                end
                START:
                begin
                    if (baud_cnt == BAUD_MID)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? IDLE : DATA;     // glitch goes back to idle
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                DATA:
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                default:                        // STOP
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        baud_cnt <= '0;
                        rdy      <= 1'b1;
                        state    <= IDLE;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample)
            shft <= {rx_s, shft[7:1]};          // lsb arrives first
    end

endmodule

/* remote_comm.sv */
module remote_comm
    import quad_cmd_pkg::*;
#(
    parameter int BAUD_DIV = 434
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  cmd_pkt_t pkt,                       // command from host
    input  logic     send_cmd,                  // start sending pkt
    output logic     cmd_sent,                  // all three bytes out
    output resp_t    resp,                      // response from craft
    output logic     resp_rdy,
    input  logic     clr_resp_rdy,
    output logic     tx,                        // to craft
    input  logic     rx                         // from craft
);

    cmd_pkt_t   pkt_q;                          // packet held during send
    logic [1:0] byte_sel;                       // 0 opcode, 1 data high, 2 data low
    logic       sending;
    logic       tx_send;
    logic       tx_done;
    logic       rx_rdy;
    resp_t      tx_byte;
    resp_t      rx_byte;
    resp_t      resp_q;

    always_comb
    begin
        case (byte_sel)
            2'd0:    tx_byte = pkt_q.opcode;
            2'd1:    tx_byte = pkt_q.data[15:8];
            default: tx_byte = pkt_q.data[7:0];
        endcase
    end

    assign resp = resp_q;

    always_ff @(posedge clk)
    begin
        if (send_cmd)
            pkt_q <= pkt;
        if (rx_rdy)
            resp_q <= rx_byte;                  // keep it past the next frame
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sending  <= 1'b0;
            byte_sel <= '0;
            tx_send  <= 1'b0;
            cmd_sent <= 1'b0;
            resp_rdy <= 1'b0;
        end
        else
        begin
            tx_send <= 1'b0;
            if (send_cmd)
            begin
                sending  <= 1'b1;
                byte_sel <= '0;
                tx_send  <= 1'b1;               // opcode goes first
                cmd_sent <= 1'b0;
            end
            else if (sending && tx_done)
            begin
                if (byte_sel == 2'd2)
                begin
                    sending  <= 1'b0;
                    cmd_sent <= 1'b1;           // held until next send_cmd
                end
                else
                begin
                    byte_sel <= byte_sel + 2'd1;
                    tx_send  <= 1'b1;
                end
            end

            if (send_cmd || clr_resp_rdy)
                resp_rdy <= 1'b0;
            else if (rx_rdy)
                resp_rdy <= 1'b1;
        end
    end

    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .byte_in (tx_byte),
        .send    (tx_send),
        .tx      (tx),
        .busy    (),
        .done    (tx_done)
    );

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .byte_out (rx_byte),
        .rdy      (rx_rdy)
    );

endmodule

/* uart_comm.sv */
module uart_comm
    import quad_cmd_pkg::*;
#(
    parameter int BAUD_DIV = 434
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx,                        // from host
    output logic     tx,                        // to host
    output cmd_pkt_t pkt,                       // assembled command
    output logic     cmd_rdy,                   // pkt complete
    input  logic     clr_cmd_rdy,
    input  resp_t    resp,                      // response byte from cmd_cfg
    input  logic     send_resp,
    output logic     resp_sent
);

    cmd_pkt_t   pkt_q;
    logic [1:0] byte_cnt;                       // bytes of current packet so far
    logic       rx_rdy;
    resp_t      rx_byte;
    logic       tx_done;

    assign pkt       = pkt_q;
    assign resp_sent = tx_done;

    // opcode shifts up to the top as data bytes follow
    always_ff @(posedge clk)
    begin
        if (rx_rdy)
            pkt_q <= cmd_pkt_t'({pkt_q[15:0], rx_byte});
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            byte_cnt <= '0;
            cmd_rdy  <= 1'b0;
        end
        else if (rx_rdy)
        begin
            if (byte_cnt == 2'd2)
            begin
                byte_cnt <= '0;
                cmd_rdy  <= 1'b1;               // third byte in
            end
            else
            begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd0)
                    cmd_rdy <= 1'b0;            // new packet starting
            end
        end
        else if (clr_cmd_rdy)
            cmd_rdy <= 1'b0;
    end

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .byte_out (rx_byte),
        .rdy      (rx_rdy)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .byte_in (resp),
        .send    (send_resp),
        .tx      (tx),
        .busy    (),
        .done    (tx_done)
    );

endmodule

/* cmd_cfg.sv */
module cmd_cfg
    import quad_cmd_pkg::*;
#(
    parameter int SPINUP_CYCLES = 1 << 20       // spin-up wait before cal
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  cmd_pkt_t pkt,
    input  logic     cmd_rdy,
    output logic     clr_cmd_rdy,               // pulse
    output resp_t    resp,
    output logic     send_resp,                 // pulse
    output setpt_t   setpt,
    output logic     strt_cal,                  // pulse to inertial integrator
    output logic     inertial_cal,              // high for spin-up and cal
    input  logic     cal_done,
    output logic     motors_off                 // to ESCs, high is safe
);

    localparam int SW = $clog2(SPINUP_CYCLES + 1);
    localparam logic [SW-1:0] SPIN_LAST = SW'(SPINUP_CYCLES - 1);

    cal_state_t    state;
    logic [SW-1:0] spin_cnt;
    setpt_t        setpt_q;
    resp_t         resp_q;

    assign setpt = setpt_q;
    assign resp  = resp_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= IDLE;
            spin_cnt     <= '0;
            setpt_q      <= '0;
            resp_q       <= RESP_ACK;
            clr_cmd_rdy  <= 1'b0;
            send_resp    <= 1'b0;
            strt_cal     <= 1'b0;
            inertial_cal <= 1'b0;
            motors_off   <= 1'b1;
        end
        else
        begin
            clr_cmd_rdy <= 1'b0;
            send_resp   <= 1'b0;
            strt_cal    <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (cmd_rdy)
                    begin
                        clr_cmd_rdy <= 1'b1;
                        resp_q      <= RESP_ACK;
                        send_resp   <= 1'b1;
                        state       <= RESP;    // let cmd_rdy drop first
                        case (pkt.opcode)
                            OP_SET_PTCH:  setpt_q.d_ptch <= pkt.data;
                            OP_SET_ROLL:  setpt_q.d_roll <= pkt.data;
                            OP_SET_YAW:   setpt_q.d_yaw  <= pkt.data;
                            OP_SET_THRST: setpt_q.thrst  <= pkt.data[8:0];
                            OP_EMER:      setpt_q        <= '0;
                            OP_MTRS_OFF:  motors_off     <= 1'b1;
                            OP_CAL:
                            begin
                                send_resp    <= 1'b0;   // answered after cal_done
                                inertial_cal <= 1'b1;
                                spin_cnt     <= '0;
                                state        <= SPINUP;
                            end
                            default:      resp_q <= RESP_NAK;   // nothing changes
                        endcase
                    end
                end
                SPINUP:
                begin
                    if (spin_cnt == SPIN_LAST)
                    begin
                        strt_cal <= 1'b1;
                        state    <= CAL;
                    end
                    else
                        spin_cnt <= spin_cnt + 1'b1;
                end
                CAL:
                begin
                    if (cal_done)               // no timeout here
                    begin
                        inertial_cal <= 1'b0;
                        motors_off   <= 1'b0;
                        send_resp    <= 1'b1;
                        state        <= RESP;
                    end
                end
                default:                        // RESP
                    state <= IDLE;
            endcase
        end
    end

endmodule

/* quad_cmd_top.sv */
module quad_cmd_top
    import quad_cmd_pkg::*;
#(
    parameter int BAUD_DIV      = 434,
    parameter int SPINUP_CYCLES = 1 << 20
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  cmd_pkt_t pkt,                       // host command
    input  logic     send_cmd,
    output logic     cmd_sent,
    output resp_t    resp,                      // response seen by host
    output logic     resp_rdy,
    input  logic     clr_resp_rdy,
    output setpt_t   setpt,
    output logic     strt_cal,
    output logic     inertial_cal,
    input  logic     cal_done,
    output logic     motors_off
);

    logic     tx_host;                          // host to craft line
    logic     tx_craft;                         // craft to host line
    cmd_pkt_t craft_pkt;
    logic     cmd_rdy;
    logic     clr_cmd_rdy;
    resp_t    craft_resp;
    logic     send_resp;

    remote_comm #(.BAUD_DIV(BAUD_DIV)) u_remote (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt          (pkt),
        .send_cmd     (send_cmd),
        .cmd_sent     (cmd_sent),
        .resp         (resp),
        .resp_rdy     (resp_rdy),
        .clr_resp_rdy (clr_resp_rdy),
        .tx           (tx_host),
        .rx           (tx_craft)
    );

    uart_comm #(.BAUD_DIV(BAUD_DIV)) u_uart (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (tx_host),
        .tx           (tx_craft),
        .pkt          (craft_pkt),
        .cmd_rdy      (cmd_rdy),
        .clr_cmd_rdy  (clr_cmd_rdy),
        .resp         (craft_resp),
        .send_resp    (send_resp),
        .resp_sent    ()
    );

    cmd_cfg #(.SPINUP_CYCLES(SPINUP_CYCLES)) u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt          (craft_pkt),
        .cmd_rdy      (cmd_rdy),
        .clr_cmd_rdy  (clr_cmd_rdy),
        .resp         (craft_resp),
        .send_resp    (send_resp),
        .setpt        (setpt),
        .strt_cal     (strt_cal),
        .inertial_cal (inertial_cal),
        .cal_done     (cal_done),
        .motors_off   (motors_off)
    );

endmodule

/* quad_cmd_tb.sv */
module quad_cmd_tb
    import quad_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BAUD_DIV      = 8;
    localparam int SPINUP_CYCLES = 64;
    localparam int TIMEOUT       = 4000;        // cycles allowed for any single wait
    localparam int DRIVE_DLY     = 1;           // input drive delay after rising edge

    logic     clk;
    logic     rst_n;
    cmd_pkt_t pkt;
    logic     send_cmd;
    logic     cmd_sent;
    resp_t    resp;
    logic     resp_rdy;
    logic     clr_resp_rdy;
    setpt_t   setpt;
    logic     strt_cal;
    logic     inertial_cal;
    logic     cal_done;
    logic     motors_off;

    logic [15:0] lfsr = 16'h0001;               // seed 1
    setpt_t      exp_sp;                        // expected setpoints
    logic        exp_mo;                        // expected motors_off
    int          strt_cnt = 0;                  // strt_cal pulses seen so far

    quad_cmd_top #(
        .BAUD_DIV      (BAUD_DIV),
        .SPINUP_CYCLES (SPINUP_CYCLES)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt          (pkt),
        .send_cmd     (send_cmd),
        .cmd_sent     (cmd_sent),
        .resp         (resp),
        .resp_rdy     (resp_rdy),
        .clr_resp_rdy (clr_resp_rdy),
        .setpt        (setpt),
        .strt_cal     (strt_cal),
        .inertial_cal (inertial_cal),
        .cal_done     (cal_done),
        .motors_off   (motors_off)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    // galois form with taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);             // one step per bit
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // expected effect of one command on setpoints, motors_off and the answer
    function automatic void predict_next(input setpt_t sp, input logic mo, input cmd_pkt_t p,
                                         output setpt_t sp_nxt, output logic mo_nxt,
                                         output resp_t r);
        sp_nxt = sp;
        mo_nxt = mo;
        r      = RESP_ACK;
        case (p.opcode)
            OP_SET_PTCH:  sp_nxt.d_ptch = p.data;
            OP_SET_ROLL:  sp_nxt.d_roll = p.data;
            OP_SET_YAW:   sp_nxt.d_yaw  = p.data;
            OP_SET_THRST: sp_nxt.thrst  = p.data[8:0];      // only 9 bits kept
            OP_CAL:       mo_nxt        = 1'b0;             // motors run after cal
            OP_EMER:      sp_nxt        = '0;
            OP_MTRS_OFF:  mo_nxt        = 1'b1;
            default:      r             = RESP_NAK;         // no state change
        endcase
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_setpt(input string name, input setpt_t got, input setpt_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_resp_rdy();
        int n;
        for (n = 0; n < TIMEOUT; n++)
        begin
            @(negedge clk);                     // outputs settled mid-cycle
            if (resp_rdy)
                break;
        end
        if (n == TIMEOUT)
        begin
            $display("timed out waiting for resp_rdy after a command was sent");
            abort_run();
        end
    endtask

    task automatic wait_inertial_cal();
        int n;
        for (n = 0; n < TIMEOUT; n++)
        begin
            @(negedge clk);
            if (inertial_cal)
                break;
        end
        if (n == TIMEOUT)
        begin
            $display("timed out waiting for inertial_cal to rise after OP_CAL");
            abort_run();
        end
    endtask

    // inertial_cal has to hold through the whole spin-up
    task automatic wait_strt_cal();
        int n;
        for (n = 0; n < TIMEOUT; n++)
        begin
            @(negedge clk);
            check_bit("inertial_cal", inertial_cal, 1'b1);
            if (strt_cal)
                break;
        end
        if (n == TIMEOUT)
        begin
            $display("timed out waiting for strt_cal during the spin-up");
            abort_run();
        end
    endtask

    task automatic issue_command(input cmd_pkt_t p);
        @(posedge clk);
        #DRIVE_DLY;
        pkt      = p;
        send_cmd = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        send_cmd = 1'b0;
    endtask

    // wait for the answer, compare with the model, then clear resp_rdy
    task automatic finish_command(input cmd_pkt_t p);
        setpt_t sp_nxt;
        logic   mo_nxt;
        resp_t  r_exp;
        wait_resp_rdy();
        predict_next(exp_sp, exp_mo, p, sp_nxt, mo_nxt, r_exp);
        exp_sp = sp_nxt;
        exp_mo = mo_nxt;
        check_resp("resp", resp, r_exp);
        check_setpt("setpt", setpt, exp_sp);
        check_bit("motors_off", motors_off, exp_mo);
        check_bit("cmd_sent", cmd_sent, 1'b1);  // all three bytes left before the answer
        @(posedge clk);
        #DRIVE_DLY;
        clr_resp_rdy = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        clr_resp_rdy = 1'b0;
        @(negedge clk);
        check_bit("resp_rdy", resp_rdy, 1'b0);
    endtask

    task automatic run_command(input opcode_t op, input data16_t data);
        cmd_pkt_t p;
        p.opcode = op;
        p.data   = data;
        issue_command(p);
        finish_command(p);
    endtask

    task automatic run_cal();
        cmd_pkt_t p;
        int       base;
        p.opcode = OP_CAL;
        p.data   = 16'h0000;
        base     = strt_cnt;
        issue_command(p);
        wait_inertial_cal();
        if (strt_cnt != base)
        begin
            $display("strt_cal pulsed before inertial_cal went high");
            abort_run();
        end
        wait_strt_cal();
        finish_command(p);
        if (strt_cnt != base + 1)
        begin
            $display("strt_cal pulsed %0d times in one calibration, expected once",
                     strt_cnt - base);
            abort_run();
        end
        check_bit("inertial_cal", inertial_cal, 1'b0);
    endtask

    // stands in for the inertial integrator and answers strt_cal with cal_done
    initial
    begin
        logic [15:0] dly;
        forever
        begin
            @(negedge clk);
            if (strt_cal)
            begin
                strt_cnt++;
                draw_bits(3, dly);              // 0..7 extra cycles
                repeat (dly + 1)
                begin
                    @(negedge clk);
                    if (strt_cal)
                        strt_cnt++;             // a second pulse gets caught here
                    check_bit("inertial_cal", inertial_cal, 1'b1);
                end
                @(posedge clk);
                #DRIVE_DLY;
                cal_done = 1'b1;
                @(posedge clk);
                #DRIVE_DLY;
                cal_done = 1'b0;
            end
        end
    end

    initial
    begin
        logic [15:0] val;
        logic [15:0] sel;
        opcode_t     op;
        rst_n        = 1'b0;
        pkt          = '0;
        send_cmd     = 1'b0;
        clr_resp_rdy = 1'b0;
        cal_done     = 1'b0;
        exp_sp       = '0;
        exp_mo       = 1'b1;                    // safe state out of reset
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("motors_off", motors_off, 1'b1);
        check_setpt("setpt", setpt, '0);
        check_bit("resp_rdy", resp_rdy, 1'b0);
        check_bit("inertial_cal", inertial_cal, 1'b0);
        check_bit("cmd_sent", cmd_sent, 1'b0);

        run_cal();

        repeat (20)
        begin
            draw_bits(2, sel);                  // pitch, roll, yaw or thrust
            draw_bits(16, val);
            run_command(OP_SET_PTCH + opcode_t'(sel), val);
        end

        run_command(OP_EMER, 16'h0000);

        run_command(OP_MTRS_OFF, 16'h0000);
        run_cal();                              // motors back on

        draw_bits(16, val);
        run_command(OP_SET_YAW, val);           // something nonzero for the nak check
        draw_bits(8, val);
        op = opcode_t'(val);
        repeat (32)
        begin
            if (op >= OP_SET_PTCH && op <= OP_MTRS_OFF)
            begin
                draw_bits(8, val);
                op = opcode_t'(val);
            end
        end
        if (op >= OP_SET_PTCH && op <= OP_MTRS_OFF)
            op = 8'hC3;                         // lfsr never left the valid range
        draw_bits(16, val);
        run_command(op, val);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
quad_cmd_pkg.sv
uart_tx.sv
uart_rx.sv
remote_comm.sv
uart_comm.sv
cmd_cfg.sv
quad_cmd_top.sv
quad_cmd_tb.sv

/* Makefile */
SIM    := verilator
TOP    := quad_cmd_tb
FLIST  := build.f
MDIR   := obj_dir
FLAGS  := --binary -j 0 --timescale 1ns/100ps -Wno-fatal --Mdir $(MDIR)

SRCS   := $(shell cat $(FLIST))
BIN    := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(MDIR)
